/* src/pipeline_pkg.sv */
package pipeline_pkg;

    localparam int NB_DATA = 32;
    localparam int NB_PC   = 32;
    localparam int NB_REG  = 5;

    // 3-bit alu opcode.
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    // memory access size, one field for all three widths.
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      load_unsigned;
        mem_size_t size;
    } ex_ctrl_t;

    typedef struct packed {
        ex_ctrl_t            ctrl;
        alu_op_t             alu_op;
        logic                alu_src_imm;
        logic [NB_PC-1:0]    pc;
        logic [NB_DATA-1:0]  data_a;
        logic [NB_DATA-1:0]  data_b;   // also the store data.
        logic [NB_DATA-1:0]  imm;      // already sign-extended.
        logic [4:0]          shamt;
        logic [NB_REG-1:0]   selected_reg;
    } id_ex_t;

    typedef struct packed {
        ex_ctrl_t            ctrl;
        logic [NB_PC-1:0]    branch_addr;
        logic                zero;
        logic [NB_DATA-1:0]  alu_result;
        logic [NB_DATA-1:0]  store_data;
        logic [NB_REG-1:0]   selected_reg;
    } ex_mem_t;

    typedef struct packed {
        logic                reg_write;
        logic [NB_REG-1:0]   selected_reg;
        logic [NB_DATA-1:0]  data;
    } wb_t;

endpackage

/* src/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
    import pipeline_pkg::*;
(
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    logic [NB_DATA-1:0] operand_b;
    logic [NB_DATA-1:0] alu_result;
    logic [NB_DATA-1:0] diff;
    logic [NB_PC-1:0]   pc_plus4;
    logic [NB_PC-1:0]   imm_offset;
    logic               less_than;

    assign operand_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.data_b;

    assign less_than = $signed(id_ex.data_a) < $signed(operand_b);

    // beq compares the two registers, never the immediate.
    assign diff = id_ex.data_a - id_ex.data_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: begin
                alu_result = id_ex.data_a + operand_b;
            end
            alu_sub: begin
                alu_result = id_ex.data_a - operand_b;
            end
            alu_and: begin
                alu_result = id_ex.data_a & operand_b;
            end
            alu_or: begin
                alu_result = id_ex.data_a | operand_b;
            end
            alu_xor: begin
                alu_result = id_ex.data_a ^ operand_b;
            end
            alu_slt: begin
                alu_result = {{(NB_DATA-1){1'b0}}, less_than}; // 0 or 1.
            end
            alu_sll: begin
                alu_result = id_ex.data_b << id_ex.shamt;
            end
            alu_srl: begin
                alu_result = id_ex.data_b >> id_ex.shamt; // logical shift.
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    assign pc_plus4   = id_ex.pc + NB_PC'(4);
    assign imm_offset = {id_ex.imm[NB_PC-3:0], 2'b00}; // word offset.

    assign ex_mem = '{
        ctrl:         id_ex.ctrl,
        branch_addr:  pc_plus4 + imm_offset,
        zero:         (diff == '0),
        alu_result:   alu_result,
        store_data:   id_ex.data_b,
        selected_reg: id_ex.selected_reg
    };

endmodule

/* src/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg
    import pipeline_pkg::*;
(
    input  logic    i_clock,
    input  logic    rst_n,
    input  ex_mem_t ex_in,
    output ex_mem_t mem_out
);

    // whole struct moves each edge.
    always_ff @(posedge i_clock) begin
        mem_out <= ex_in;
        if (!rst_n) begin
            mem_out.ctrl <= '0; // first mem cycle is a bubble.
        end
    end

endmodule

/* src/mem_access_unit.sv */
`timescale 1ns/1ps

module mem_access_unit
    import pipeline_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic             i_clock,
    input  ex_mem_t          mem_in,
    output wb_t              wb,
    output logic             pc_src,
    output logic [NB_PC-1:0] branch_target
);

    logic [3:0][7:0]           mem [2**MEM_ADDR_BITS];

    logic [MEM_ADDR_BITS-1:0]  word_addr;
    logic [1:0]                byte_off;
    logic [3:0]                lane_en;
    logic [3:0][7:0]           wr_data;
    logic [3:0][7:0]           rd_word;
    logic [7:0]                rd_byte;
    logic [15:0]               rd_half;
    logic [NB_DATA-1:0]        load_data;

    // word address wraps at the memory depth.
    assign word_addr = mem_in.alu_result[MEM_ADDR_BITS+1:2];
    assign byte_off  = mem_in.alu_result[1:0];

    always_comb begin
        case (mem_in.ctrl.size)
            size_byte: begin
                lane_en = 4'b0001 << byte_off;
                wr_data = {4{mem_in.store_data[7:0]}};
            end
            size_half: begin
                lane_en = byte_off[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{mem_in.store_data[15:0]}};
            end
            default: begin
                lane_en = 4'b1111; // word, low bits ignored.
                wr_data = mem_in.store_data;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (mem_in.ctrl.mem_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_en[lane]) begin
                    mem[word_addr][lane] <= wr_data[lane];
                end
            end
        end
    end

    assign rd_word = mem[word_addr];
    assign rd_byte = rd_word[byte_off];
    assign rd_half = byte_off[1] ? {rd_word[3], rd_word[2]} : {rd_word[1], rd_word[0]};

    always_comb begin
        case (mem_in.ctrl.size)
            size_byte: begin
                if (mem_in.ctrl.load_unsigned) begin
                    load_data = {{(NB_DATA-8){1'b0}}, rd_byte};
                end else begin
                    load_data = {{(NB_DATA-8){rd_byte[7]}}, rd_byte};
                end
            end
            size_half: begin
                if (mem_in.ctrl.load_unsigned) begin
                    load_data = {{(NB_DATA-16){1'b0}}, rd_half};
                end else begin
                    load_data = {{(NB_DATA-16){rd_half[15]}}, rd_half};
                end
            end
            default: begin
                load_data = rd_word;
            end
        endcase
    end

    assign wb = '{
        reg_write:    mem_in.ctrl.reg_write,
        selected_reg: mem_in.selected_reg,
        data:         mem_in.ctrl.mem_to_reg ? load_data : mem_in.alu_result
    };

    // taken only for a branch with equal operands.
    assign pc_src        = mem_in.ctrl.branch & mem_in.zero;
    assign branch_target = mem_in.branch_addr;

endmodule

/* src/ex_mem_stage_top.sv */
`timescale 1ns/1ps

module ex_mem_stage_top
    import pipeline_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic             i_clock,
    input  logic             rst_n,
    input  id_ex_t           id_ex,
    output wb_t              wb,
    output logic             pc_src,
    output logic [NB_PC-1:0] branch_target
);

    ex_mem_t ex_to_reg;
    ex_mem_t reg_to_mem;

    // ex stage, combinational.
    execute_unit i_execute_unit (
        .id_ex  (id_ex),
        .ex_mem (ex_to_reg)
    );

    ex_mem_reg i_ex_mem_reg (
        .i_clock (i_clock),
        .rst_n   (rst_n),
        .ex_in   (ex_to_reg),
        .mem_out (reg_to_mem)
    );

    // mem stage, writes at end of cycle.
    mem_access_unit #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) i_mem_access_unit (
        .i_clock       (i_clock),
        .mem_in        (reg_to_mem),
        .wb            (wb),
        .pc_src        (pc_src),
        .branch_target (branch_target)
    );

endmodule

/* verif/ex_mem_stage_checker.sv */
`timescale 1ns/1ps

module ex_mem_stage_checker
    import pipeline_pkg::*;
(
    input logic     i_clock,
    input logic     rst_n,
    input ex_ctrl_t ctrl,
    input logic     pc_src
);

    // a reset edge leaves a bubble behind it.
    property p_reset_clears_ctrl;
        @(posedge i_clock) !rst_n |=> (ctrl == '0);
    endproperty

    property p_taken_needs_branch;
        @(posedge i_clock) pc_src |-> ctrl.branch;
    endproperty

    property p_no_read_and_write;
        @(posedge i_clock) !$isunknown(ctrl) |-> !(ctrl.mem_read && ctrl.mem_write);
    endproperty

    a_reset_clears_ctrl: assert property (p_reset_clears_ctrl)
        else $error("ctrl not cleared after a reset edge");

    a_taken_needs_branch: assert property (p_taken_needs_branch)
        else $error("pc_src high without branch");

    a_no_read_and_write: assert property (p_no_read_and_write)
        else $error("mem_read and mem_write both high");

endmodule

// reg copy watches reset, mem copy watches the branch decision.
bind ex_mem_reg ex_mem_stage_checker i_reg_checker (
    .i_clock (i_clock),
    .rst_n   (rst_n),
    .ctrl    (mem_out.ctrl),
    .pc_src  (1'b0)
);

bind mem_access_unit ex_mem_stage_checker i_mem_checker (
    .i_clock (i_clock),
    .rst_n   (1'b1),
    .ctrl    (mem_in.ctrl),
    .pc_src  (pc_src)
);

/* verif/ex_mem_stage_tb.sv */
`timescale 1ns/1ps

module ex_mem_stage_tb
    import pipeline_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int MEM_ADDR_BITS   = 8;
    localparam int MEM_BYTES       = 4 * (2 ** MEM_ADDR_BITS);
    localparam int ALU_COUNT       = 200;
    localparam int BRANCH_COUNT    = 100;
    localparam int FILL_WORDS      = 32;  // loads stay inside this window.
    localparam int STORE_COUNT     = 40;
    localparam int MIXED_COUNT     = 400;
    localparam int TOTAL_CYCLES    = 8 + ALU_COUNT + BRANCH_COUNT + FILL_WORDS
                                     + 6 * STORE_COUNT + MIXED_COUNT;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic             i_clock;
    logic             rst_n;
    id_ex_t           id_ex;
    wb_t              wb;
    logic             pc_src;
    logic [NB_PC-1:0] branch_target;

    logic [31:0]      lfsr_state = 32'hdd15_5571;
    logic [7:0]       mem_model [int];
    id_ex_t           pending_q [$];  // instruction now in mem.
    int               store_addrs [$];
    string            test_name;
    int               test_errors;
    int               test_checks;
    int               tests_passed;
    int               tests_failed;

    ex_mem_stage_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) i_ex_mem_stage_top (
        .i_clock       (i_clock),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .wb            (wb),
        .pc_src        (pc_src),
        .branch_target (branch_target)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic mem_size_t pick_size();
        logic [31:0] r;
        r = rand_bits(2);
        case (r[1:0])
            2'd0:    return size_byte;
            2'd1:    return size_half;
            default: return size_word;
        endcase
    endfunction

    // random operands, control all zero.
    function automatic id_ex_t random_fields();
        id_ex_t      x;
        logic [15:0] h;
        x = '0;
        x.alu_op       = alu_op_t'(3'(rand_bits(3)));
        x.alu_src_imm  = 1'(rand_bits(1));
        x.pc           = rand_bits(30) << 2;
        x.data_a       = rand_bits(32);
        x.data_b       = rand_bits(32);
        h              = 16'(rand_bits(16));
        x.imm          = {{16{h[15]}}, h};
        x.shamt        = 5'(rand_bits(5));
        x.selected_reg = NB_REG'(rand_bits(5));
        return x;
    endfunction

    function automatic id_ex_t make_alu();
        id_ex_t x;
        x = random_fields();
        x.ctrl.reg_write = 1'b1;
        return x;
    endfunction

    function automatic id_ex_t make_branch();
        id_ex_t x;
        x = random_fields();
        x.alu_op      = alu_sub;
        x.alu_src_imm = 1'b0;
        if (rand_bits(1) == 32'd1) begin
            x.data_b = x.data_a;  // taken.
        end
        x.ctrl.branch = 1'b1;
        return x;
    endfunction

    function automatic id_ex_t mem_op(input int addr, input logic store,
                                      input mem_size_t size, input logic uns);
        id_ex_t x;
        x = random_fields();
        x.alu_op      = alu_add;
        x.alu_src_imm = 1'b1;
        x.imm         = rand_bits(4);  // small offset from the base.
        x.data_a      = addr - x.imm;
        x.ctrl.size   = size;
        if (store) begin
            x.ctrl.mem_write = 1'b1;
        end else begin
            x.ctrl.mem_read      = 1'b1;
            x.ctrl.mem_to_reg    = 1'b1;
            x.ctrl.reg_write     = 1'b1;
            x.ctrl.load_unsigned = uns;
        end
        return x;
    endfunction

    function automatic logic [31:0] alu_model(input id_ex_t x);
        logic [31:0] b;
        b = x.alu_src_imm ? x.imm : x.data_b;
        case (x.alu_op)
            alu_add: return x.data_a + b;
            alu_sub: return x.data_a - b;
            alu_and: return x.data_a & b;
            alu_or:  return x.data_a | b;
            alu_xor: return x.data_a ^ b;
            alu_slt: return ($signed(x.data_a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sll: return x.data_b << x.shamt;
            default: return x.data_b >> x.shamt;  // srl.
        endcase
    endfunction

    function automatic logic [31:0] load_model(input id_ex_t x, input logic [31:0] addr);
        int         ba;
        int         base;
        int         hb;
        logic [7:0] b0;
        logic [7:0] b1;
        ba   = int'(addr & 32'(MEM_BYTES - 1));  // wraps with the memory.
        base = ba - ba % 4;
        hb   = (ba % 4 >= 2) ? base + 2 : base;
        case (x.ctrl.size)
            size_byte: begin
                b0 = mem_model[ba];
                return x.ctrl.load_unsigned ? {24'h0, b0} : {{24{b0[7]}}, b0};
            end
            size_half: begin
                b0 = mem_model[hb];
                b1 = mem_model[hb + 1];
                return x.ctrl.load_unsigned ? {16'h0, b1, b0} : {{16{b1[7]}}, b1, b0};
            end
            default: begin
                return {mem_model[base + 3], mem_model[base + 2],
                        mem_model[base + 1], mem_model[base]};
            end
        endcase
    endfunction

    function automatic void store_model(input id_ex_t x, input logic [31:0] addr);
        int ba;
        int base;
        int hb;
        ba   = int'(addr & 32'(MEM_BYTES - 1));
        base = ba - ba % 4;
        hb   = (ba % 4 >= 2) ? base + 2 : base;
        case (x.ctrl.size)
            size_byte: mem_model[ba] = x.data_b[7:0];
            size_half: begin
                mem_model[hb]     = x.data_b[7:0];
                mem_model[hb + 1] = x.data_b[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    mem_model[base + i] = x.data_b[8*i +: 8];
                end
            end
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic check_outputs(input id_ex_t x);
        logic [31:0] result;
        logic [31:0] exp_data;
        logic [31:0] exp_target;
        logic        exp_pc_src;
        result     = alu_model(x);
        exp_data   = x.ctrl.mem_to_reg ? load_model(x, result) : result;
        exp_pc_src = x.ctrl.branch && (x.data_a == x.data_b);
        exp_target = x.pc + 32'd4 + (x.imm << 2);
        if (wb.reg_write !== x.ctrl.reg_write) begin
            report_mismatch("wb reg_write", 32'(x.ctrl.reg_write), 32'(wb.reg_write));
        end
        if (wb.selected_reg !== x.selected_reg) begin
            report_mismatch("wb selected_reg", 32'(x.selected_reg), 32'(wb.selected_reg));
        end
        if (wb.data !== exp_data) begin
            report_mismatch("wb data", exp_data, wb.data);
        end
        if (pc_src !== exp_pc_src) begin
            report_mismatch("pc_src", 32'(exp_pc_src), 32'(pc_src));
        end
        if (branch_target !== exp_target) begin
            report_mismatch("branch_target", exp_target, branch_target);
        end
        test_checks++;
        if (x.ctrl.mem_write) begin
            store_model(x, result);  // lands at the end of its mem cycle.
        end
    endtask

    task automatic issue(input id_ex_t x);
        @(negedge i_clock);
        if (pending_q.size() > 0) begin
            check_outputs(pending_q.pop_front());
        end
        id_ex = x;
        pending_q.push_back(x);
    endtask

    task automatic drain();
        @(negedge i_clock);
        if (pending_q.size() > 0) begin
            check_outputs(pending_q.pop_front());
        end
        id_ex = '0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        drain();
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic load_all_sizes(input int addr);
        issue(mem_op(addr, 1'b0, size_byte, 1'b0));
        issue(mem_op(addr, 1'b0, size_byte, 1'b1));
        issue(mem_op(addr, 1'b0, size_half, 1'b0));
        issue(mem_op(addr, 1'b0, size_half, 1'b1));
        issue(mem_op(addr, 1'b0, size_word, 1'b0));
    endtask

    initial begin
        id_ex_t x;
        int     addr;
        rst_n        = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        x = random_fields();
        x.data_b         = x.data_a;
        x.ctrl.reg_write = 1'b1;
        x.ctrl.branch    = 1'b1;  // taken if reset did not clear it.
        id_ex = x;

        start_test("reset");
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        if (wb.reg_write !== 1'b0) begin
            report_mismatch("wb reg_write", 32'd0, 32'(wb.reg_write));
        end
        if (pc_src !== 1'b0) begin
            report_mismatch("pc_src", 32'd0, 32'(pc_src));
        end
        test_checks++;
        rst_n = 1'b1;
        id_ex = '0;
        finish_test();

        start_test("alu_ops");
        for (int i = 0; i < ALU_COUNT; i++) begin
            issue(make_alu());
        end
        finish_test();

        start_test("branches");
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            issue(make_branch());
        end
        finish_test();

        start_test("load_store");
        for (int i = 0; i < FILL_WORDS; i++) begin
            issue(mem_op(4 * i, 1'b1, size_word, 1'b0));
        end
        for (int i = 0; i < STORE_COUNT; i++) begin
            addr = int'(rand_bits(7));  // inside the filled window.
            store_addrs.push_back(addr);
            issue(mem_op(addr, 1'b1, pick_size(), 1'b0));
        end
        foreach (store_addrs[i]) begin
            load_all_sizes(store_addrs[i]);
        end
        finish_test();

        start_test("mixed_stream");
        for (int i = 0; i < MIXED_COUNT; i++) begin
            case (3'(rand_bits(3)))
                3'd0, 3'd1: x = make_alu();
                3'd2:       x = mem_op(int'(rand_bits(7)), 1'b0, pick_size(), 1'(rand_bits(1)));
                3'd3:       x = mem_op(int'(rand_bits(10)), 1'b1, pick_size(), 1'b0);
                3'd4, 3'd5: x = make_branch();
                default:    x = random_fields();  // bubble.
            endcase
            issue(x);
        end
        finish_test();

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* project.f */
src/pipeline_pkg.sv
src/execute_unit.sv
src/ex_mem_reg.sv
src/mem_access_unit.sv
src/ex_mem_stage_top.sv
verif/ex_mem_stage_checker.sv
verif/ex_mem_stage_tb.sv

/* Makefile */
TOP := ex_mem_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "simulation reported errors, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
